// ==== build.f ====
+incdir+hw
hw/cpuTypes.sv
hw/alu.sv
hw/control.sv
hw/datapath.sv
hw/cpu.sv
bench/cpu_checker.sv
bench/cpuMonitor.sv
bench/cpuTb.sv

// ==== Makefile ====
# Verilator build and run of the core testbench

VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = cpuTb
FILELIST  = build.f
OBJDIR    = obj_dir
SIMFLAGS  = +verilator+error+limit+100
LOG       = sim.log
PASSMSG   = Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) $(SIMFLAGS) | tee $(LOG)
	grep -q "^$(PASSMSG)$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== bench/cpuTb.sv ====
// Core testbench: clock, reset, program assembly, memory model and final report
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module cpuTb;

   import cpuTypes::*;

   logic                   Clock;
   logic                   nReset;
   logic [`DATA_WIDTH-1:0] BusIn;
   wire  [`DATA_WIDTH-1:0] BusOut;
   wire                    ALE, nME, nOE, nWE;
   logic [15:0]            mem [256];
   logic [15:0]            memAddr;
   logic                   done;
   int                     monErrors, monStores, p, cycles, timeouts;

   cpu dut (.Clock(Clock), .nReset(nReset), .BusIn(BusIn), .BusOut(BusOut),
            .ALE(ALE), .nME(nME), .nOE(nOE), .nWE(nWE));

   cpuMonitor monitor (.Clock(Clock), .nReset(nReset), .BusOut(BusOut), .ALE(ALE),
                       .nME(nME), .nWE(nWE), .Image(mem), .Done(done),
                       .Errors(monErrors), .Stores(monStores));

   always #4 Clock = ~Clock;

   // Memory model on the multiplexed bus
   assign BusIn = (!nME && !nOE) ? mem[memAddr[7:0]] : 16'h0000;

   always @(posedge Clock) begin
      if (ALE)
         memAddr <= BusOut;
      if (!nME && !nWE)
         mem[memAddr[7:0]] <= BusOut;
   end

   task automatic put(input logic [15:0] w);
      mem[p] = w;
      p++;
   endtask

   function automatic logic [15:0] encR(opcode_t op, int rd, int ra, int rb);
      return {op, 3'(rd), 3'(ra), 3'(rb), 2'b00};
   endfunction

   function automatic logic [15:0] encI(opcode_t op, int rd, logic [7:0] imm);
      return {op, 3'(rd), imm};
   endfunction

   task automatic storeReg(input int r);   // STW r,[r0] then advance r0
      put({OpStw, 3'(r), 3'd0, 5'd0});
      put(encI(OpAddi, 0, 8'd1));
   endtask

   task automatic loadConst(input int r);
      put(encI(OpLui, r, 8'($urandom)));
      put(encI(OpLli, r, 8'($urandom)));
   endtask

   task automatic buildProgram();
      opcode_t aluOps [7];
      branch_t conds [4];
      aluOps = '{OpAdd, OpSub, OpAdc, OpAnd, OpOr, OpXor, OpNot};
      conds = '{CondBe, CondBne, CondBlt, CondBge};
      for (int i = 0; i < 256; i++)
         mem[i] = {8'(i) ^ 8'hA5, ~8'(i)};   // Filler, never executed
      p = 0;
      put(encI(OpLui, 0, 8'h00));
      put(encI(OpLli, 0, 8'hC0));   // Store pointer
      loadConst(1);
      loadConst(2);
      for (int i = 0; i < 7; i++) begin
         put(encR(aluOps[i], 3, 1, 2));
         storeReg(3);
      end
      storeReg(1);                  // LUI/LLI composition
      put(encI(OpAddi, 1, 8'hFB));
      storeReg(1);
      put(encI(OpSubi, 2, 8'hFD));
      storeReg(2);
      put(encI(OpLsl, 1, 8'($urandom) & 8'h0F));
      storeReg(1);
      put(encI(OpLsr, 2, 8'($urandom) & 8'h0F));
      storeReg(2);
      for (int k = 0; k < 3; k++) begin
         loadConst(1);
         loadConst(2);
         if (k == 2)
            put(encR(OpOr, 2, 1, 1));   // Equal pair
         for (int c = 0; c < 4; c++) begin
            put(encR(OpCmp, 0, 1, 2));
            put(encI(OpBranch, conds[c], 8'd3));
            put(encI(OpLli, 4, 8'(16 * k + c + 1)));   // Marker when not taken
            storeReg(4);
         end
      end
      put(encI(OpBranch, CondBwl, 8'd4));
      put(encI(OpBranch, CondBr, 8'd7));
      put(encI(OpLli, 4, 8'hBB));   // Skipped code
      storeReg(4);
      put(encI(OpLli, 4, 8'h77));   // Subroutine
      storeReg(4);
      put(encI(OpBranch, CondRet, 8'd0));
      loadConst(5);
      put({OpStw, 3'd5, 3'd0, 5'd0});
      put({OpLdw, 3'd6, 3'd0, 5'd0});
      put(encI(OpAddi, 0, 8'd1));
      storeReg(6);
      put(encI(OpLui, 7, 8'h00));
      put(encI(OpLli, 7, 8'hFF));
      put(encI(OpLli, 4, 8'hA5));
      put({OpStw, 3'd4, 3'd7, 5'd0});   // Completion marker at 255
      put(encI(OpBranch, CondBr, 8'hFF));
   endtask

   initial begin
      Clock = 1'b0;
      nReset = 1'b0;
      memAddr = '0;
      timeouts = 0;
      void'($urandom(62384));
      buildProgram();
      repeat (3) @(posedge Clock);
      nReset <= 1'b1;
      for (cycles = 0; cycles < 20000 && !done; cycles++)
         @(posedge Clock);
      if (!done) begin
         $display("Timeout: no completion store within 20000 cycles");
         timeouts++;
      end
      $display("Errors: %0d store, %0d protocol, %0d timeout (%0d stores seen)",
               monErrors, dut.protocolCheck.violations, timeouts, monStores);
      if (monErrors == 0 && dut.protocolCheck.violations == 0 && timeouts == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/cpuMonitor.sv ====
// Store monitor running an ISA reference model of the program image and checking observed stores
`timescale 1ns/1ps
`default_nettype none

module cpuMonitor (
   input  wire         Clock,
   input  wire         nReset,
   input  wire  [15:0] BusOut,
   input  wire         ALE,
   input  wire         nME,
   input  wire         nWE,
   input  logic [15:0] Image [256],
   output logic        Done,
   output int          Errors,
   output int          Stores
);

   import cpuTypes::*;

   logic [15:0] expAddr [64];
   logic [15:0] expData [64];
   int          expCount;
   logic        ready;
   logic        sawAle;
   logic        prevWrite;
   logic        writing;
   logic [15:0] latchedAddr;

   // Runs the program over a copy of the image until the store to address 255
   function automatic int runModel();
      logic [15:0] r [8];
      logic [15:0] m [256];
      logic [15:0] pc, nextPc, lr, w, a, b, res, simm, addr;
      logic [16:0] sum;
      logic [3:0]  nzcv;
      logic        cin, arith, wr, flg, take;
      int          sSum;
      int          n;
      n = 0;
      pc = '0;
      lr = '0;
      nzcv = '0;
      sum = '0;
      sSum = 0;
      for (int i = 0; i < 8; i++)
         r[i] = '0;
      for (int i = 0; i < 256; i++)
         m[i] = Image[i];
      for (int step = 0; step < 4000 && n < 64; step++) begin
         w = m[pc[7:0]];
         simm = {{8{w[7]}}, w[7:0]};
         addr = r[w[7:5]] + {{11{w[4]}}, w[4:0]};
         a = r[w[7:5]];
         b = r[w[4:2]];
         res = '0;
         arith = 1'b0;
         cin = 1'b0;
         wr = 1'b1;
         flg = 1'b1;
         nextPc = pc + 16'd1;
         case (opcode_t'(w[15:11]))
            OpAdd:  arith = 1'b1;
            OpAddi: begin
               a = r[w[10:8]];
               b = simm;
               arith = 1'b1;
            end
            OpSub: begin
               b = ~b;
               cin = 1'b1;
               arith = 1'b1;
            end
            OpSubi: begin
               a = r[w[10:8]];
               b = ~simm;
               cin = 1'b1;
               arith = 1'b1;
            end
            OpAdc: begin
               cin = nzcv[1];
               arith = 1'b1;
            end
            OpCmp: begin
               b = ~b;
               cin = 1'b1;
               arith = 1'b1;
               wr = 1'b0;
            end
            OpAnd:  res = a & b;
            OpOr:   res = a | b;
            OpXor:  res = a ^ b;
            OpNot:  res = ~a;
            OpLsl:  res = r[w[10:8]] << w[3:0];
            OpLsr:  res = r[w[10:8]] >> w[3:0];
            OpLui: begin
               res = {w[7:0], 8'h00};
               flg = 1'b0;
            end
            OpLli: begin
               res = {r[w[10:8]][15:8], w[7:0]};
               flg = 1'b0;
            end
            OpLdw: begin
               res = m[addr[7:0]];
               flg = 1'b0;
            end
            OpStw: begin
               m[addr[7:0]] = r[w[10:8]];
               expAddr[n] = addr;
               expData[n] = r[w[10:8]];
               n++;
               if (addr == 16'd255)
                  return n;
               wr = 1'b0;
               flg = 1'b0;
            end
            OpBranch: begin
               wr = 1'b0;
               flg = 1'b0;
               case (branch_t'(w[10:8]))
                  CondBr, CondBwl: take = 1'b1;
                  CondBe:  take = nzcv[2];
                  CondBne: take = !nzcv[2];
                  CondBlt: take = nzcv[3] != nzcv[0];
                  CondBge: take = nzcv[3] == nzcv[0];
                  default: take = 1'b0;
               endcase
               if (branch_t'(w[10:8]) == CondRet)
                  nextPc = lr;
               else if (take) begin
                  nextPc = pc + 16'd1 + simm;
                  if (branch_t'(w[10:8]) == CondBwl)
                     lr = pc + 16'd1;
               end
            end
            default: begin
               wr = 1'b0;
               flg = 1'b0;
            end
         endcase
         if (arith) begin
            sum = {1'b0, a} + {1'b0, b} + {16'd0, cin};
            res = sum[15:0];
            sSum = int'($signed(a)) + int'($signed(b)) + int'(cin);
         end
         // Signed overflow when the exact sum leaves the 16-bit range
         if (flg)
            nzcv = {res[15], res == 16'd0, arith & sum[16],
                    arith && (sSum > 32767 || sSum < -32768)};
         if (wr)
            r[w[10:8]] = res;
         pc = nextPc;
      end
      return n;
   endfunction

   always @(posedge Clock) begin
      if (!nReset) begin
         ready = 1'b0;
         sawAle = 1'b0;
         prevWrite = 1'b0;
         Done = 1'b0;
         Errors = 0;
         Stores = 0;
         latchedAddr = '0;
      end else begin
         if (!ready) begin
            expCount = runModel();   // Image is still untouched by stores here
            ready = 1'b1;
         end
         if (ALE) begin
            latchedAddr = BusOut;
            if (!sawAle && BusOut != 16'd0) begin
               $display("[FAIL] %0t ns: BusOut first fetch address expected 0000 got %h",
                        $time, BusOut);
               Errors++;
            end
            sawAle = 1'b1;
         end
         writing = !nME && !nWE;
         if (writing && !prevWrite && !Done) begin   // One event per STW
            if (Stores >= expCount) begin
               $display("Unexpected store to address %h at %0t ns", latchedAddr, $time);
               Errors++;
            end else begin
               if (latchedAddr !== expAddr[Stores]) begin
                  $display("[FAIL] %0t ns: BusOut store address expected %h got %h",
                           $time, expAddr[Stores], latchedAddr);
                  Errors++;
               end
               if (BusOut !== expData[Stores]) begin
                  $display("[FAIL] %0t ns: BusOut store data expected %h got %h",
                           $time, expData[Stores], BusOut);
                  Errors++;
               end
            end
            Stores++;
            if (latchedAddr == 16'd255) begin
               Done = 1'b1;
               if (Stores != expCount) begin
                  $display("Completion store came after %0d stores instead of %0d",
                           Stores, expCount);
                  Errors++;
               end
            end
         end
         prevWrite = writing;
      end
   end

endmodule

`default_nettype wire

// ==== bench/cpu_checker.sv ====
// Bus protocol checker for strobe exclusivity and ALE spacing on the core's memory bus
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
   input wire Clock,
   input wire nReset,
   input wire ALE,
   input wire nME,
   input wire nOE,
   input wire nWE
);

   int violations = 0;

   oeWeExclusive: assert property (@(posedge Clock) disable iff (!nReset)
      !(!nOE && !nWE))
      else begin
         $error("nOE and nWE are low in the same cycle");
         violations++;
      end

   aleOutsideAccess: assert property (@(posedge Clock) disable iff (!nReset)
      !(ALE && !nME))
      else begin
         $error("ALE is high while nME is low");
         violations++;
      end

   // A 4-cycle gap is allowed only after a data ALE that came 5 cycles after its fetch
   aleSpacing: assert property (@(posedge Clock) disable iff (!nReset)
      ALE |-> (!($past(ALE, 1) || $past(ALE, 2) || $past(ALE, 3))
               && (!$past(ALE, 4) || $past(ALE, 9))))
      else begin
         $error("ALE pulses are closer than the bus cycle timing allows");
         violations++;
      end

endmodule

bind cpu cpu_checker protocolCheck (
   .Clock  (Clock),
   .nReset (nReset),
   .ALE    (ALE),
   .nME    (nME),
   .nOE    (nOE),
   .nWE    (nWE)
);

`default_nettype wire

// ==== hw/cpu.sv ====
// Core top: controller and datapath on one multiplexed memory bus
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module cpu (
   input  wire                   Clock,
   input  wire                   nReset,
   input  wire [`DATA_WIDTH-1:0] BusIn,
   output wire [`DATA_WIDTH-1:0] BusOut,
   output wire                   ALE,
   output wire                   nME,
   output wire                   nOE,
   output wire                   nWE
);

   import cpuTypes::*;

   ctrl_t      Ctrl;
   instr_t     Instr;
   logic [3:0] Flags;     // ALU flags before the status register
   logic       CarryIn;

   control controller (
      .Clock   (Clock),
      .nReset  (nReset),
      .Instr   (Instr),
      .Flags   (Flags),
      .Ctrl    (Ctrl),
      .CarryIn (CarryIn),
      .ALE     (ALE),
      .nME     (nME),
      .nOE     (nOE),
      .nWE     (nWE)
   );

   datapath dataPath (
      .Clock   (Clock),
      .nReset  (nReset),
      .Ctrl    (Ctrl),
      .CarryIn (CarryIn),
      .BusIn   (BusIn),
      .BusOut  (BusOut),
      .Instr   (Instr),
      .Flags   (Flags)
   );

endmodule

`default_nettype wire

// ==== hw/datapath.sv ====
// Datapath with instruction register, PC, LR, register file, operand muxes, ALU and bus output
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module datapath (
   input  wire                    Clock,
   input  wire                    nReset,
   input  wire cpuTypes::ctrl_t   Ctrl,
   input  wire                    CarryIn,
   input  wire [`DATA_WIDTH-1:0]  BusIn,
   output logic [`DATA_WIDTH-1:0] BusOut,
   output cpuTypes::instr_t       Instr,
   output logic [3:0]             Flags
);

   import cpuTypes::*;

   logic [`DATA_WIDTH-1:0]      regFile [`NUM_REGS];
   logic [`DATA_WIDTH-1:0]      pc;
   logic [`DATA_WIDTH-1:0]      lr;
   logic [`DATA_WIDTH-1:0]      pcPlus1;
   logic [`DATA_WIDTH-1:0]      nextPc;
   logic [`DATA_WIDTH-1:0]      aluReg;
   logic [`DATA_WIDTH-1:0]      busLatch;
   logic [`DATA_WIDTH-1:0]      imm;
   logic [`DATA_WIDTH-1:0]      opA;
   logic [`DATA_WIDTH-1:0]      opB;
   logic [`DATA_WIDTH-1:0]      aluResult;
   logic [`DATA_WIDTH-1:0]      wrData;
   logic [`REG_FIELD_WIDTH-1:0] aIdx;

   assign pcPlus1 = pc + {{(`DATA_WIDTH-1){1'b0}}, 1'b1};
   assign aIdx = Ctrl.rdAsA ? Instr.regForm.rd : Instr.regForm.ra;

   always_comb begin
      if (Ctrl.immSel == ImmShort)
         imm = {{(`DATA_WIDTH-5){Instr.immForm.imm[4]}}, Instr.immForm.imm[4:0]};
      else
         imm = {{(`DATA_WIDTH-8){Instr.immForm.imm[7]}}, Instr.immForm.imm};
   end

   // Branch targets are formed from PC+1
   assign opA = (Ctrl.pcSel == PcAlu) ? pcPlus1 : regFile[aIdx];
   assign opB = (Ctrl.op2Sel == Op2Imm) ? imm : regFile[Instr.regForm.rb];

   alu aluUnit (
      .A       (opA),
      .B       (opB),
      .Fn      (Ctrl.aluFn),
      .CarryIn (CarryIn),
      .Result  (aluResult),
      .Flags   (Flags)
   );

   assign wrData = (Ctrl.wdSel == WdBus) ? busLatch : aluResult;

   always_comb begin
      case (Ctrl.pcSel)
         PcAlu:   nextPc = aluResult;
         PcLr:    nextPc = lr;
         default: nextPc = pcPlus1;
      endcase
   end

   always_comb begin
      if (Ctrl.addrOut)
         BusOut = aluReg;
      else if (Ctrl.dataOut)
         BusOut = regFile[Instr.regForm.rd];   // Store data
      else
         BusOut = pc;
   end

   always_ff @(posedge Clock) begin
      busLatch <= BusIn;   // Read data held for the cycle after the strobes
      if (Ctrl.aluWe)
         aluReg <= aluResult;
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         pc <= '0;
         lr <= '0;
         Instr <= '0;
         for (int i = 0; i < `NUM_REGS; i++)
            regFile[i] <= '0;
      end else begin
         if (Ctrl.irWe)
            Instr <= instr_t'(busLatch);
         if (Ctrl.pcWe)
            pc <= nextPc;
         if (Ctrl.lrWe)
            lr <= pcPlus1;   // Return address
         if (Ctrl.regWe)
            regFile[Instr.regForm.rd] <= wrData;
      end
   end

endmodule

`default_nettype wire

// ==== hw/control.sv ====
// Controller: fetch/execute sequencer, NZCV status register, branch decisions and bus strobes
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module control (
   input  wire                   Clock,
   input  wire                   nReset,
   input  wire cpuTypes::instr_t Instr,
   input  wire [3:0]             Flags,
   output cpuTypes::ctrl_t       Ctrl,
   output logic                  CarryIn,
   output logic                  ALE,
   output logic                  nME,
   output logic                  nOE,
   output logic                  nWE
);

   import cpuTypes::*;

   typedef enum logic {Fetch, Execute} phase_t;

   phase_t     phase;
   logic [2:0] cycle;
   logic       started;     // Low for the first cycle out of reset
   logic [3:0] statusReg;
   logic       statusWe;
   logic       taken;
   logic       memOp;
   opcode_t    opcode;
   branch_t    cond;

   assign opcode = Instr.regForm.opcode;
   assign cond = branch_t'(Instr.immForm.rd);
   assign memOp = (opcode == OpLdw) || (opcode == OpStw);
   assign CarryIn = statusReg[`FLAG_C];

   always_comb begin
      case (cond)
         CondBr, CondBwl: taken = 1'b1;
         CondBe:  taken = statusReg[`FLAG_Z];
         CondBne: taken = !statusReg[`FLAG_Z];
         CondBlt: taken = statusReg[`FLAG_N] ^ statusReg[`FLAG_V];
         CondBge: taken = !(statusReg[`FLAG_N] ^ statusReg[`FLAG_V]);
         default: taken = 1'b0;
      endcase
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         started <= 1'b0;
         phase <= Fetch;
         cycle <= '0;
         statusReg <= '0;
      end else begin
         started <= 1'b1;
         if (statusWe)
            statusReg <= Flags;
         if (started) begin
            if (phase == Fetch) begin
               if (cycle == 3'd3) begin
                  phase <= Execute;
                  cycle <= '0;
               end else
                  cycle <= cycle + 3'd1;
            end else if ((cycle == 3'd0 && !memOp) || cycle == 3'd4) begin
               phase <= Fetch;
               cycle <= '0;
            end else
               cycle <= cycle + 3'd1;
         end
      end
   end

   always_comb begin
      Ctrl = '0;             // PASSA, register operand, ALU write data, PC+1
      statusWe = 1'b0;
      ALE = 1'b0;
      nME = 1'b1;
      nOE = 1'b1;
      nWE = 1'b1;
      case (opcode)
         OpAdd, OpAddi, OpLdw, OpStw, OpBranch: Ctrl.aluFn = AluAdd;
         OpSub, OpSubi, OpCmp: Ctrl.aluFn = AluSub;
         OpAdc: Ctrl.aluFn = AluAdc;
         OpAnd: Ctrl.aluFn = AluAnd;
         OpOr:  Ctrl.aluFn = AluOr;
         OpXor: Ctrl.aluFn = AluXor;
         OpNot: Ctrl.aluFn = AluNot;
         OpLsl: Ctrl.aluFn = AluLsl;
         OpLsr: Ctrl.aluFn = AluLsr;
         OpLui: Ctrl.aluFn = AluLui;
         OpLli: Ctrl.aluFn = AluLli;
         default: Ctrl.aluFn = AluPassA;
      endcase
      if (phase == Fetch) begin
         case (cycle)
            3'd0: ALE = started;   // PC on the bus
            3'd1, 3'd2: begin
               nME = 1'b0;
               nOE = 1'b0;
            end
            3'd3: Ctrl.irWe = 1'b1;
            default: ;
         endcase
      end else begin
         case (cycle)
            3'd0: begin
               Ctrl.pcWe = !memOp;
               case (opcode)
                  OpAdd, OpSub, OpAdc, OpAnd, OpOr, OpXor, OpNot: begin
                     Ctrl.regWe = 1'b1;
                     statusWe = 1'b1;
                  end
                  OpCmp: statusWe = 1'b1;
                  OpAddi, OpSubi, OpLsl, OpLsr: begin
                     Ctrl.op2Sel = Op2Imm;
                     Ctrl.rdAsA = 1'b1;
                     Ctrl.regWe = 1'b1;
                     statusWe = 1'b1;
                  end
                  OpLui, OpLli: begin
                     Ctrl.op2Sel = Op2Imm;
                     Ctrl.rdAsA = (opcode == OpLli);   // Keeps the high byte of rd
                     Ctrl.regWe = 1'b1;
                  end
                  OpLdw, OpStw: begin
                     Ctrl.op2Sel = Op2Imm;
                     Ctrl.immSel = ImmShort;
                     Ctrl.aluWe = 1'b1;   // Effective address
                  end
                  OpBranch: begin
                     Ctrl.op2Sel = Op2Imm;
                     if (cond == CondRet)
                        Ctrl.pcSel = PcLr;
                     else if (taken) begin
                        Ctrl.pcSel = PcAlu;
                        Ctrl.lrWe = (cond == CondBwl);
                     end
                  end
                  default: ;
               endcase
            end
            3'd1: begin
               ALE = 1'b1;
               Ctrl.addrOut = 1'b1;
            end
            3'd2, 3'd3: begin
               nME = 1'b0;
               nOE = (opcode != OpLdw);
               nWE = (opcode != OpStw);
               Ctrl.dataOut = (opcode == OpStw);
            end
            3'd4: begin
               Ctrl.pcWe = 1'b1;
               if (opcode == OpLdw) begin
                  Ctrl.wdSel = WdBus;
                  Ctrl.regWe = 1'b1;
               end
            end
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
// ALU: arithmetic, logic, shift and immediate-merge functions with NZCV flags
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module alu (
   input  wire [`DATA_WIDTH-1:0]  A,
   input  wire [`DATA_WIDTH-1:0]  B,
   input  wire cpuTypes::aluFn_t  Fn,
   input  wire                    CarryIn,
   output logic [`DATA_WIDTH-1:0] Result,
   output logic [3:0]             Flags
);

   import cpuTypes::*;

   logic [`DATA_WIDTH:0]   sum;
   logic [`DATA_WIDTH-1:0] bOp;
   logic                   cIn;
   logic                   arith;

   always_comb begin
      arith = (Fn == AluAdd) || (Fn == AluAdc) || (Fn == AluSub);
      bOp = (Fn == AluSub) ? ~B : B;   // A + not B + 1
      if (Fn == AluSub)
         cIn = 1'b1;
      else if (Fn == AluAdc)
         cIn = CarryIn;
      else
         cIn = 1'b0;
      sum = {1'b0, A} + {1'b0, bOp} + {{`DATA_WIDTH{1'b0}}, cIn};

      case (Fn)
         AluAdd, AluAdc, AluSub: Result = sum[`DATA_WIDTH-1:0];
         AluAnd: Result = A & B;
         AluOr:  Result = A | B;
         AluXor: Result = A ^ B;
         AluNot: Result = ~A;
         AluLsl: Result = A << B[3:0];
         AluLsr: Result = A >> B[3:0];
         AluLui: Result = {B[7:0], 8'h00};
         AluLli: Result = {A[`DATA_WIDTH-1:8], B[7:0]};
         default: Result = A;
      endcase

      Flags[`FLAG_N] = Result[`DATA_WIDTH-1];
      Flags[`FLAG_Z] = (Result == '0);
      Flags[`FLAG_C] = arith & sum[`DATA_WIDTH];
      // Overflow when both inputs agree in sign and the result does not
      Flags[`FLAG_V] = arith & (A[`DATA_WIDTH-1] == bOp[`DATA_WIDTH-1])
                             & (Result[`DATA_WIDTH-1] != A[`DATA_WIDTH-1]);
   end

endmodule

`default_nettype wire

// ==== hw/cpuTypes.sv ====
// Shared core types: opcodes, branch codes, ALU functions, selects, instruction and control word
`default_nettype none
`include "cpu_config.svh"

package cpuTypes;

   // LDW/STW are rd, ra with a 5-bit signed offset in bits 4..0
   typedef enum logic [`OPCODE_WIDTH-1:0] {
      OpAdd  = 5'h00, OpAddi = 5'h01, OpSub = 5'h02, OpSubi = 5'h03,
      OpAdc  = 5'h04, OpCmp  = 5'h05, OpAnd = 5'h06, OpOr   = 5'h07,
      OpXor  = 5'h08, OpNot  = 5'h09, OpLsl = 5'h0A, OpLsr  = 5'h0B,
      OpLui  = 5'h0C, OpLli  = 5'h0D, OpLdw = 5'h0E, OpStw  = 5'h0F,
      OpBranch = 5'h10
   } opcode_t;

   typedef enum logic [`REG_FIELD_WIDTH-1:0] {
      CondBr  = 3'd0, CondBe  = 3'd1, CondBne = 3'd2, CondBlt = 3'd3,
      CondBge = 3'd4, CondBwl = 3'd5, CondRet = 3'd6
   } branch_t;

   typedef enum logic [3:0] {
      AluPassA, AluAdd, AluAdc, AluSub, AluAnd, AluOr,
      AluXor, AluNot, AluLsl, AluLsr, AluLui, AluLli
   } aluFn_t;

   typedef enum logic {Op2Reg, Op2Imm} op2Sel_t;
   typedef enum logic {WdAlu, WdBus} wdSel_t;
   typedef enum logic [1:0] {PcInc, PcAlu, PcLr} pcSel_t;
   typedef enum logic {ImmLong, ImmShort} immSel_t;   // Signed imm8 or signed bits 4..0

   typedef struct packed {
      opcode_t                                                  opcode;
      logic [`REG_FIELD_WIDTH-1:0]                              rd;
      logic [`REG_FIELD_WIDTH-1:0]                              ra;
      logic [`REG_FIELD_WIDTH-1:0]                              rb;
      logic [`DATA_WIDTH-`OPCODE_WIDTH-3*`REG_FIELD_WIDTH-1:0] spare;
   } regForm_t;

   typedef struct packed {
      opcode_t                                               opcode;
      logic [`REG_FIELD_WIDTH-1:0]                           rd;   // Branch code for OpBranch
      logic [`DATA_WIDTH-`OPCODE_WIDTH-`REG_FIELD_WIDTH-1:0] imm;
   } immForm_t;

   typedef union packed {
      regForm_t regForm;
      immForm_t immForm;
   } instr_t;

   typedef struct packed {
      aluFn_t  aluFn;
      op2Sel_t op2Sel;
      immSel_t immSel;
      wdSel_t  wdSel;
      pcSel_t  pcSel;
      logic    regWe;
      logic    pcWe;
      logic    irWe;
      logic    lrWe;
      logic    aluWe;
      logic    addrOut;   // ALU latch onto the bus instead of PC
      logic    dataOut;   // Register rd onto the bus
      logic    rdAsA;     // Port A reads rd instead of ra
   } ctrl_t;

endpackage

`default_nettype wire

// ==== hw/cpu_config.svh ====
// Core configuration: word size, register count, instruction field widths, NZCV bit positions
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define DATA_WIDTH      16   // Registers, addresses and bus
`define NUM_REGS        8
`define OPCODE_WIDTH    5    // Instruction bits 15..11
`define REG_FIELD_WIDTH 3

// Status word bit positions
`define FLAG_N 3
`define FLAG_Z 2
`define FLAG_C 1
`define FLAG_V 0

`endif
